/* tb.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/decode_if.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/rv_core_top.sv
verification/rv_core_checker.sv
verification/tb_top.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/decode_if.sv
      - hdl/inst_decoder.sv
      - hdl/reg_file.sv
      - hdl/exec_unit.sv
      - hdl/rv_core_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/rv_core_checker.sv
      - verification/tb_top.sv

/* verification/tb_top.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

module tb_top import rv_pkg::*; ();

    localparam int          NPROG      = 4;
    localparam int          NWORDS     = 512;
    localparam int          BODY       = NWORDS - 32;  // dumps and ebreak follow
    localparam int          HOLD       = 8;
    localparam int          CLK_PERIOD = 20;
    localparam longint      TIMEOUT_NS = NPROG * NWORDS * CLK_PERIOD * 2;
    localparam logic [31:0] SEED       = 32'h5f8a00af;
    localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic                   clk;
    logic                   rst_n;
    logic [31:0]            inst;
    logic [`RV_XLEN-1:0]    pc;
    logic                   st_we;
    logic [`RV_XLEN-1:0]    st_addr;
    logic [`RV_XLEN-1:0]    st_data;
    logic [`RV_XLEN/8-1:0]  st_strb;
    logic                   ecall;
    logic                   halted;

    logic [31:0]            imem [NWORDS];
    logic [31:0]            lfsr = SEED;
    logic [`RV_XLEN-1:0]    m_regs [`RV_NREGS];  // model state
    logic [`RV_XLEN-1:0]    m_pc;
    logic                   m_halted;

    rv_core_top dut (
        .clk (clk), .rst_n (rst_n), .inst (inst),
        .pc (pc), .st_we (st_we), .st_addr (st_addr),
        .st_data (st_data), .st_strb (st_strb),
        .ecall (ecall), .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] j_imm(input rv_inst_u w);
        return {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
    endfunction

    function automatic logic [31:0] fetch(input logic [`RV_XLEN-1:0] addr);
        if (addr[31:2] < NWORDS) begin
            return imem[addr[10:2]];
        end else begin
            return 32'h0;  // past the ebreak
        end
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return (sa < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return sa >>> b[4:0];
                else     return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // one random body word, jal only jumps forward inside the body
    function automatic logic [31:0] rand_inst(input int idx);
        logic [3:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        logic [20:0] off;
        rv_inst_u    w;
        sel = 4'(take_bits(4));
        rd  = 5'(take_bits(5));
        rs1 = 5'(take_bits(5));
        rs2 = 5'(take_bits(5));
        f3  = 3'(take_bits(3));
        imm = 12'(take_bits(12));
        w   = '0;
        case (sel)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd15: begin
                if (f3 == 3'b001) imm[11:5] = 7'b0;
                if (f3 == 3'b101) imm[11:5] = {1'b0, imm[10], 5'b0};  // srli / srai
                w = {imm, rs1, f3, rd, OP_IMM};
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                alt = take_bits(1) && (f3 == 3'b000 || f3 == 3'b101);
                w   = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
            end
            4'd9:  w = {20'(take_bits(20)), rd, OP_LUI};
            4'd10: w = {20'(take_bits(20)), rd, OP_AUIPC};
            4'd11: begin
                off = 21'(4 * (1 + take_bits(9) % (BODY - idx)));
                w.j.imm20    = off[20];
                w.j.imm10_1  = off[10:1];
                w.j.imm11    = off[11];
                w.j.imm19_12 = off[19:12];
                w.j.rd       = rd;
                w.j.opcode   = OP_JAL;
            end
            4'd12: begin
                f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
                w  = {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
            end
            4'd13: w = ECALL_WORD;
            default: begin
                case (2'(take_bits(2)))
                    2'd0:    w = {25'(take_bits(25)), 7'b0000011};  // load
                    2'd1:    w = {25'(take_bits(25)), 7'b1100011};  // branch
                    default: w = {imm, rs1, 3'b001, rd, OP_SYS};    // csr access
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic gen_program();
        logic [11:0] off;
        for (int i = 0; i < BODY; i++) begin
            imem[i] = rand_inst(i);
        end
        // sw x1..x31 to 0x404.. then stop
        for (int k = 1; k < 32; k++) begin
            off = 12'h400 + 12'(4 * k);
            imem[BODY + k - 1] = {off[11:5], 5'(k), 5'd0, 3'b010, off[4:0], OP_STORE};
        end
        imem[NWORDS - 1] = EBREAK_WORD;
    endtask

    task automatic model_reset();
        for (int r = 0; r < `RV_NREGS; r++) begin
            m_regs[r] = '0;
        end
        m_pc     = `RV_RESET_PC;
        m_halted = 1'b0;
    endtask

    task automatic model_step();
        rv_inst_u    w;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        w   = fetch(m_pc);
        res = '0;
        wr  = 1'b1;
        nxt = m_pc + 32'd4;
        case (w.r.opcode)
            OP_IMM:   res = alu(w.i.funct3, w.i.funct3 == 3'b101 && w.i.imm[10],
                                m_regs[w.i.rs1], sext12(w.i.imm));
            OP_REG:   res = alu(w.r.funct3, w.r.funct7[5], m_regs[w.r.rs1], m_regs[w.r.rs2]);
            OP_LUI:   res = {w.u.imm, 12'b0};
            OP_AUIPC: res = m_pc + {w.u.imm, 12'b0};
            OP_JAL: begin
                res = m_pc + 32'd4;  // link
                nxt = m_pc + j_imm(w);
            end
            default: begin
                wr = 1'b0;
                if (w == EBREAK_WORD) m_halted = 1'b1;
            end
        endcase
        if (wr && w.r.rd != 5'd0) m_regs[w.r.rd] = res;
        m_pc = nxt;
    endtask

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) stop_fail($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_strb(input string name, input logic [`RV_XLEN/8-1:0] got,
                              input logic [`RV_XLEN/8-1:0] exp);
        if (got !== exp) stop_fail($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) stop_fail($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // outputs of the instruction now at pc, sampled mid-cycle
    task automatic compare_cycle();
        rv_inst_u              w;
        logic [`RV_XLEN-1:0]   addr;
        logic [`RV_XLEN-1:0]   b;
        logic [`RV_XLEN-1:0]   data;
        logic [`RV_XLEN/8-1:0] strb;
        w = fetch(m_pc);
        check_word("pc", pc, m_pc);
        check_bit("halted", halted, 1'b0);
        check_bit("ecall", ecall, w == ECALL_WORD);
        check_bit("st_we", st_we, w.r.opcode == OP_STORE);
        if (w.r.opcode == OP_STORE) begin
            b    = m_regs[w.s.rs2];
            addr = m_regs[w.s.rs1] + sext12({w.s.imm_hi, w.s.imm_lo});
            case (w.s.funct3)
                3'b000: begin
                    data = {4{b[7:0]}};
                    strb = '0;
                    strb[addr[1:0]] = 1'b1;  // the addressed byte only
                end
                3'b001: begin
                    data = {2{b[15:0]}};
                    strb = addr[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    data = b;
                    strb = 4'b1111;
                end
            endcase
            check_word("st_addr", st_addr, addr);
            check_word("st_data", st_data, data);
            check_strb("st_strb", st_strb, strb);
        end
    endtask

    task automatic run_program();
        gen_program();
        model_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        inst  <= '0;  // opcode 0 decodes as illegal
        repeat (16) begin
            @(negedge clk);
            check_word("pc", pc, `RV_RESET_PC);
            check_bit("halted", halted, 1'b0);
            check_bit("st_we", st_we, 1'b0);
            check_bit("ecall", ecall, 1'b0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        inst  <= fetch(m_pc);
        while (!m_halted) begin
            @(negedge clk);
            compare_cycle();
            model_step();
            @(posedge clk);
            inst <= fetch(m_pc);
        end
        // stores and ecalls offered while halted must stay masked
        repeat (HOLD) begin
            @(negedge clk);
            check_bit("halted", halted, 1'b1);
            check_word("pc", pc, m_pc);
            check_bit("st_we", st_we, 1'b0);
            check_bit("ecall", ecall, 1'b0);
            @(posedge clk);
            inst <= take_bits(1) ? ECALL_WORD : imem[BODY];
        end
    endtask

    initial begin
        rst_n = 1'b0;
        inst  = '0;
        for (int p = 0; p < NPROG; p++) begin
            run_program();
        end
        @(negedge clk);
        if (dut.u_exe.u_chk.fails != 0) begin
            stop_fail($sformatf("%0d assertion failures in the execute unit",
                                dut.u_exe.u_chk.fails));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_fail("timeout, the core did not reach ebreak in every program");
    end

endmodule

`default_nettype wire

/* verification/rv_core_checker.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

module rv_core_checker import rv_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input inst_class_e          cls,
    input logic                 is_auipc,
    input logic [`RV_XLEN-1:0]  rs1_data,
    input logic [`RV_XLEN-1:0]  rs2_data,
    input logic [`RV_XLEN-1:0]  pc
);

    int unsigned fails = 0;  // failed assertion count

    // x0 stays hard zero, rs2 is steered to it outside R and S
    a_rs2_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (cls != CLS_R && cls != CLS_S) |-> rs2_data == '0)
        else begin
            $error("x0 read back nonzero on the rs2 port");
            fails++;
        end

    // lui source is forced to x0 by the decoder
    a_lui_rs1_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (cls == CLS_U && !is_auipc) |-> rs1_data == '0)
        else begin
            $error("lui source did not read x0");
            fails++;
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            fails++;
        end

endmodule

bind exec_unit rv_core_checker u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .cls      (bus.cls),
    .is_auipc (bus.is_auipc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc)
);

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

module rv_core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             inst,     // word at pc, same cycle
    output logic [`RV_XLEN-1:0]     pc,
    output logic                    st_we,
    output logic [`RV_XLEN-1:0]     st_addr,
    output logic [`RV_XLEN-1:0]     st_data,
    output logic [`RV_XLEN/8-1:0]   st_strb,
    output logic                    ecall,
    output logic                    halted
);

    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                we;
    logic [4:0]          waddr;
    logic [`RV_XLEN-1:0] wdata;

    decode_if dbus ();

    inst_decoder u_dec (
        .inst (inst),
        .bus  (dbus.dec)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dbus.rs1),
        .rs2      (dbus.rs2),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exe (
        .clk (clk), .rst_n (rst_n),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .bus (dbus.exe),
        .we (we), .waddr (waddr), .wdata (wdata),
        .pc (pc), .st_we (st_we), .st_addr (st_addr),
        .st_data (st_data), .st_strb (st_strb),
        .ecall (ecall), .halted (halted)
    );

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

module exec_unit import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    decode_if.exe                   bus,
    output logic                    we,
    output logic [4:0]              waddr,
    output logic [`RV_XLEN-1:0]     wdata,
    output logic [`RV_XLEN-1:0]     pc,
    output logic                    st_we,
    output logic [`RV_XLEN-1:0]     st_addr,
    output logic [`RV_XLEN-1:0]     st_data,
    output logic [`RV_XLEN/8-1:0]   st_strb,
    output logic                    ecall,
    output logic                    halted
);

    localparam int NB = `RV_XLEN / 8;  // byte lanes

    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_next;
    logic [4:0]          shamt;
    logic                writes_rd;
    logic                is_ebreak;

    assign op_b  = (bus.cls == CLS_R) ? rs2_data : bus.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (bus.funct3)
            3'b000:  alu_res = bus.alt ? rs1_data - op_b : rs1_data + op_b;
            3'b001:  alu_res = rs1_data << shamt;
            3'b010:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            3'b011:  alu_res = {{(`RV_XLEN-1){1'b0}}, rs1_data < op_b};
            3'b100:  alu_res = rs1_data ^ op_b;
            3'b101:  alu_res = bus.alt ? $unsigned($signed(rs1_data) >>> shamt)
                                       : rs1_data >> shamt;
            3'b110:  alu_res = rs1_data | op_b;
            default: alu_res = rs1_data & op_b;
        endcase
    end

    assign pc_plus4 = pc + `RV_XLEN'(4);
    assign pc_next  = (bus.cls == CLS_J) ? pc + bus.imm : pc_plus4;

    // write-back select
    always_comb begin
        case (bus.cls)
            CLS_U:   wdata = bus.is_auipc ? pc + bus.imm : bus.imm;
            CLS_J:   wdata = pc_plus4;  // link
            default: wdata = alu_res;
        endcase
    end

    assign writes_rd = (bus.cls == CLS_I) || (bus.cls == CLS_R) ||
                       (bus.cls == CLS_U) || (bus.cls == CLS_J);
    assign we        = !halted && writes_rd && (bus.rd != 5'd0);
    assign waddr     = bus.rd;

    // store path, size from funct3
    assign st_we   = !halted && (bus.cls == CLS_S);
    assign st_addr = rs1_data + bus.imm;

    always_comb begin
        case (bus.funct3[1:0])
            2'b00: begin
                st_data = {NB{rs2_data[7:0]}};
                st_strb = NB'(1) << st_addr[1:0];
            end
            2'b01: begin
                st_data = {(NB/2){rs2_data[15:0]}};
                st_strb = NB'(3) << {st_addr[1], 1'b0};
            end
            default: begin
                st_data = rs2_data;
                st_strb = '1;
            end
        endcase
    end

    assign ecall     = !halted && (bus.cls == CLS_N) && (bus.sys == SYS_ECALL);
    assign is_ebreak = (bus.cls == CLS_N) && (bus.sys == SYS_EBREAK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `RV_RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            pc     <= pc_next;    // ebreak still retires
            halted <= is_ebreak;
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

module reg_file #(
    parameter int AW = $clog2(`RV_NREGS)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [AW-1:0]        rs1,
    input  logic [AW-1:0]        rs2,
    input  logic                 we,
    input  logic [AW-1:0]        waddr,
    input  logic [`RV_XLEN-1:0]  wdata,
    output logic [`RV_XLEN-1:0]  rs1_data,
    output logic [`RV_XLEN-1:0]  rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is skipped here so it stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

module inst_decoder import rv_pkg::*; (
    input  rv_inst_u   inst,
    decode_if.dec      bus
);

    inst_class_e cls;
    logic        sys_zero_word;
    logic        is_lui;

    // major opcode to class
    always_comb begin
        case (inst.r.opcode)
            OP_IMM:            cls = CLS_I;
            OP_SYS:            cls = CLS_N;
            OP_LUI, OP_AUIPC:  cls = CLS_U;
            OP_REG:            cls = CLS_R;
            OP_STORE:          cls = CLS_S;
            OP_JAL:            cls = CLS_J;
            default:           cls = CLS_BAD;
        endcase
    end

    assign is_lui = (inst.r.opcode == OP_LUI);

    // ecall and ebreak differ only in imm bit 0
    assign sys_zero_word = (inst.i.rs1 == 5'd0) && (inst.i.funct3 == 3'd0) &&
                           (inst.i.rd == 5'd0);

    always_comb begin
        if (sys_zero_word && inst.i.imm == 12'h000) begin
            bus.sys = SYS_ECALL;
        end else if (sys_zero_word && inst.i.imm == 12'h001) begin
            bus.sys = SYS_EBREAK;
        end else begin
            bus.sys = SYS_OTHER;
        end
    end

    assign bus.cls      = cls;
    assign bus.is_auipc = (inst.r.opcode == OP_AUIPC);
    assign bus.funct3   = inst.r.funct3;
    assign bus.rd       = inst.r.rd;

    // funct7[5] picks sub/sra for R, srai only among the I shifts
    always_comb begin
        if (cls == CLS_R) begin
            bus.alt = inst.r.funct7[5];
        end else if (cls == CLS_I && inst.r.funct3 == 3'b101) begin
            bus.alt = inst.r.funct7[5];
        end else begin
            bus.alt = 1'b0;
        end
    end

    // lui reads no source, x0 keeps the datapath quiet
    assign bus.rs1 = is_lui ? 5'd0 : inst.r.rs1;

    always_comb begin
        if (cls == CLS_R || cls == CLS_S) begin
            bus.rs2 = inst.r.rs2;
        end else begin
            bus.rs2 = 5'd0;
        end
    end

    // immediate by class
    always_comb begin
        case (cls)
            CLS_I: begin
                bus.imm = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            end
            CLS_S: begin
                bus.imm = {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            end
            CLS_U: begin
                bus.imm = {inst.u.imm, 12'b0};
            end
            CLS_J: begin
                bus.imm = {{(`RV_XLEN-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                           inst.j.imm11, inst.j.imm10_1, 1'b0};
            end
            default: begin
                bus.imm = '0;  // R and N carry none
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decode_if.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"
`default_nettype none

interface decode_if import rv_pkg::*; ();

    inst_class_e          cls;
    sys_kind_e            sys;
    logic                 is_auipc;
    logic [2:0]           funct3;
    logic                 alt;       // sub / sra / srai select
    logic [4:0]           rd;
    logic [4:0]           rs1;       // read by the register file only
    logic [4:0]           rs2;
    logic [`RV_XLEN-1:0]  imm;

    // decoder side
    modport dec (
        output cls, sys, is_auipc, funct3, alt,
        output rd, rs1, rs2, imm
    );

    // execute side, source indices go straight to the register file
    modport exe (
        input cls, sys, is_auipc, funct3, alt,
        input rd, imm
    );

endinterface

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,
        OP_SYS   = 7'b1110011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_REG   = 7'b0110011,
        OP_STORE = 7'b0100011,
        OP_JAL   = 7'b1101111
    } opcode_e;

    // instruction class, same codes as the old decode key
    typedef enum logic [2:0] {
        CLS_I   = 3'b000,  // register-immediate arith
        CLS_N   = 3'b001,  // ecall / ebreak
        CLS_U   = 3'b010,
        CLS_R   = 3'b011,
        CLS_S   = 3'b100,
        CLS_J   = 3'b101,
        CLS_BAD = 3'b111
    } inst_class_e;

    typedef enum logic [1:0] {
        SYS_ECALL  = 2'd0,
        SYS_EBREAK = 2'd1,
        SYS_OTHER  = 2'd2  // retired as a no-op
    } sys_kind_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;  // upper 20 bits of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // jal offset bits are scrambled in the word
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

endpackage

`default_nettype wire

/* hdl/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`default_nettype none

// data path and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

`define RV_RESET_PC 32'h0000_0000  // first fetch after reset

`default_nettype wire

`endif
